// ==== src.f ====
+incdir+common
common/wr_mux_pkg.sv
design/req_arbiter.sv
design/cmd_fifo.sv
wr_mux/stream_mux_wr.sv
design/user_wr_top.sv
sim/tb_user_wr.sv

// ==== run.sh ====
#!/bin/sh
# Build the write path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f src.f \
  --top-module tb_user_wr -o tb_user_wr

out=$(./obj_dir/tb_user_wr)
printf '%s\n' "$out"

# Result decided by the testbench's closing line
if printf '%s\n' "$out" | grep -q "^Finished with no errors$"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== sim/tb_user_wr.sv ====
/*
 * Testbench for the user write path
 * Channel requests and write streams against a reference model,
 * random back-pressure on both memory handshakes, beat by beat checks
 */
`timescale 1ns/1ps
`include "wr_mux_config.svh"

module tb_user_wr;

  import wr_mux_pkg::*;

  localparam int N     = `WR_N_CHAN;
  localparam int BYTES = `WR_DATA_BITS / 8;
  localparam int NTEST = 4;
  localparam int MAXR  = 4;

  // Test table
  string test_names [NTEST] = '{"same_cycle", "burst_order", "rand_tready", "fifo_fill"};
  int    nreq_all [NTEST]   = '{1, 3, 3, 4};
  int    first_lens [4]     = '{1, 8, 64, 13};

  logic          aclk;
  logic          aresetn;
  logic [N-1:0]  req_valid;
  logic [N-1:0]  req_ready;
  len_t [N-1:0]  req_len;
  logic [N-1:0]  s_tvalid;
  logic [N-1:0]  s_tready;
  data_t [N-1:0] s_tdata;
  keep_t [N-1:0] s_tkeep;
  logic [N-1:0]  s_tlast;
  logic          mreq_valid;
  logic          mreq_ready;
  len_t          mreq_len;
  chan_t         mreq_chan;
  logic          m_tvalid;
  logic          m_tready;
  data_t         m_tdata;
  keep_t         m_tkeep;
  chan_t         m_tid;
  logic          m_tlast;

  // Byte lengths per test, channel and request
  int   lens_all [NTEST][N][MAXR+1];
  int   cur_test = 0;
  logic running = 1'b0;
  int   err_cnt = 0;
  int   bursts_done = 0;
  bit   saw_full = 1'b0;
  int   cycles = 0;
  int   cycle_limit = 1000000;

  // Comparison state: grant order and position in the running burst
  int rr = 0;
  int gcnt [N];
  int bq_chan [$];
  int bq_req [$];
  int beat_i = 0;

  user_wr_top user_wr_top_inst (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_len    (req_len),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .s_tkeep    (s_tkeep),
    .s_tlast    (s_tlast),
    .mreq_valid (mreq_valid),
    .mreq_ready (mreq_ready),
    .mreq_len   (mreq_len),
    .mreq_chan  (mreq_chan),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .m_tkeep    (m_tkeep),
    .m_tid      (m_tid),
    .m_tlast    (m_tlast)
  );

  // -------------------------------------------------------------------------
  // Reference model
  // -------------------------------------------------------------------------
  // Beat count rounds the byte length up, zero length is one beat
  function automatic void ref_beat(input int t, input int c, input int r, input int k,
                                   output int nbeats, output data_t data,
                                   output keep_t keep, output logic last);
    int len;
    int rem;
    len    = lens_all[t][c][r];
    nbeats = (len == 0) ? 1 : (len + BYTES - 1) / BYTES;
    rem    = len % BYTES;
    last   = (k == nbeats - 1);
    keep   = '1;
    // Partial last beat keeps only the remaining bytes
    if (last && rem != 0) begin
      keep = keep_t'((1 << rem) - 1);
    end
    data = data_t'({8'(c), 8'(t), 16'(r), 32'(k)});
  endfunction

  task automatic show_mismatch(input string what, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
    $display("ERROR %s: %s expected %h actual %h", test_names[cur_test], what, exp_v, act_v);
    err_cnt++;
  endtask

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // -------------------------------------------------------------------------
  // Channel stimulus, all DUT data inputs driven 1 ns after the edge
  // -------------------------------------------------------------------------
  initial begin : stimulus
    logic [N-1:0] req_hs;
    logic [N-1:0] dat_hs;
    int    req_idx [N];
    int    dat_req [N];
    int    dat_beat [N];
    int    nb;
    data_t d;
    keep_t k;
    logic  l;
    bit    rand_tr;
    bit    rand_mq;
    req_valid  = '0;
    req_len    = '0;
    s_tvalid   = '0;
    s_tdata    = '0;
    s_tkeep    = '0;
    s_tlast    = '0;
    mreq_ready = 1'b0;
    m_tready   = 1'b0;
    forever begin
      @(posedge aclk);
      req_hs = req_valid & req_ready;
      dat_hs = s_tvalid & s_tready;
      #1;
      rand_tr = (cur_test >= 2);
      rand_mq = (cur_test == 3);
      for (int c = 0; c < N; c++) begin
        if (!running) begin
          req_idx[c]  = 0;
          dat_req[c]  = 0;
          dat_beat[c] = 0;
        end else begin
          if (req_hs[c]) begin
            req_idx[c]++;
          end
          if (dat_hs[c]) begin
            ref_beat(cur_test, c, dat_req[c], dat_beat[c], nb, d, k, l);
            dat_beat[c]++;
            if (dat_beat[c] == nb) begin
              dat_beat[c] = 0;
              dat_req[c]++;
            end
          end
        end
        // Next request raised right after a grant, without waiting for data
        req_valid[c] = running && (req_idx[c] < nreq_all[cur_test]);
        req_len[c]   = len_t'(lens_all[cur_test][c][req_idx[c]]);
        // Data only for granted requests, an offered beat holds until taken
        if (!running) begin
          s_tvalid[c] = 1'b0;
        end else if (!s_tvalid[c] || dat_hs[c]) begin
          s_tvalid[c] = (dat_req[c] < req_idx[c]) && (!rand_tr || ($urandom % 4) != 0);
        end
        ref_beat(cur_test, c, dat_req[c], dat_beat[c], nb, d, k, l);
        s_tdata[c] = d;
        s_tkeep[c] = k;
        s_tlast[c] = l;
      end
      mreq_ready = !rand_mq || (($urandom % 2) == 1);
      m_tready   = !rand_tr || (($urandom % 3) != 0);
    end
  end

  // -------------------------------------------------------------------------
  // Comparison of memory requests and beats
  // -------------------------------------------------------------------------
  always @(posedge aclk) begin : compare
    int           exp_c;
    int           head_c;
    int           nb;
    data_t        d;
    keep_t        k;
    logic         l;
    logic [N-1:0] exp_rdy;
    logic [N-1:0] stray_rdy;
    if (!aresetn) begin
      rr = 0;
    end
    if (!running) begin
      bq_chan.delete();
      bq_req.delete();
      beat_i      = 0;
      bursts_done = 0;
      saw_full    = 1'b0;
      for (int c = 0; c < N; c++) begin
        gcnt[c] = 0;
      end
    end else begin
      // Ready only towards the oldest unfinished burst
      head_c = -1;
      if (bq_chan.size() != 0) begin
        head_c = bq_chan[0];
      end
      stray_rdy = '0;
      for (int c = 0; c < N; c++) begin
        if (s_tready[c] && !(c == head_c && m_tready)) begin
          stray_rdy[c] = 1'b1;
        end
      end
      if (stray_rdy != '0) begin
        $display("Test %s: s_tready %b raised outside the running burst",
                 test_names[cur_test], s_tready);
        err_cnt++;
      end
      exp_rdy = '0;
      if (mreq_valid && mreq_ready) begin
        // First requesting channel at or after the pointer
        exp_c = -1;
        for (int i = 0; i < N; i++) begin
          if (exp_c < 0 && req_valid[(rr + i) % N]) begin
            exp_c = (rr + i) % N;
          end
        end
        if (exp_c < 0) begin
          $display("Test %s: memory request issued with no channel requesting",
                   test_names[cur_test]);
          err_cnt++;
        end else begin
          if (mreq_chan != chan_t'(exp_c)) begin
            show_mismatch("mreq_chan", 64'(exp_c), 64'(mreq_chan));
          end
          if (mreq_len != len_t'(lens_all[cur_test][exp_c][gcnt[exp_c]])) begin
            show_mismatch("mreq_len", 64'(lens_all[cur_test][exp_c][gcnt[exp_c]]),
                          64'(mreq_len));
          end
          exp_rdy[exp_c] = 1'b1;
          bq_chan.push_back(exp_c);
          bq_req.push_back(gcnt[exp_c]);
          gcnt[exp_c]++;
          rr = (exp_c + 1) % N;
        end
      end
      // Grant goes to one channel, and only with the memory handshake
      if (req_ready != exp_rdy) begin
        show_mismatch("req_ready", 64'(exp_rdy), 64'(req_ready));
      end
      if (m_tvalid && m_tready) begin
        if (bq_chan.size() == 0) begin
          $display("Test %s: beat on the memory stream with no burst granted",
                   test_names[cur_test]);
          err_cnt++;
        end else begin
          ref_beat(cur_test, bq_chan[0], bq_req[0], beat_i, nb, d, k, l);
          if (m_tid != chan_t'(bq_chan[0])) begin
            show_mismatch("m_tid", 64'(bq_chan[0]), 64'(m_tid));
          end
          if (m_tdata != d) begin
            show_mismatch("m_tdata", 64'(d), 64'(m_tdata));
          end
          if (m_tkeep != k) begin
            show_mismatch("m_tkeep", 64'(k), 64'(m_tkeep));
          end
          if (m_tlast != l) begin
            show_mismatch("m_tlast", 64'(l), 64'(m_tlast));
          end
          beat_i++;
          // Burst closed, next one follows grant order
          if (beat_i == nb) begin
            void'(bq_chan.pop_front());
            void'(bq_req.pop_front());
            beat_i = 0;
            bursts_done++;
          end
        end
      end
      if (user_wr_top_inst.cmd_full) begin
        saw_full = 1'b1;
      end
    end
  end

  always @(posedge aclk) begin : watchdog
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the memory stream stopped delivering beats",
               cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------
  initial begin : main
    int    nb;
    data_t d;
    keep_t k;
    logic  l;
    int    total_beats;
    int    errs_before;
    int    failed;
    bit    test_bad;
    void'($urandom(32'h4f27_44f2));
    aresetn     = 1'b0;
    failed      = 0;
    total_beats = 0;
    // Lengths, 1 byte and exact beat multiples among them
    for (int t = 0; t < NTEST; t++) begin
      for (int c = 0; c < N; c++) begin
        for (int r = 0; r <= MAXR; r++) begin
          case (t)
            0: lens_all[t][c][r] = first_lens[c % 4];
            1: lens_all[t][c][r] = (r == 1) ? BYTES * (c + 2) : ((c * 29 + r * 11) % 70) + 1;
            2: lens_all[t][c][r] = 1 + int'($urandom % 96);
            default: lens_all[t][c][r] = 9 + int'($urandom % 88);
          endcase
        end
      end
    end
    for (int t = 0; t < NTEST; t++) begin
      for (int c = 0; c < N; c++) begin
        for (int r = 0; r < nreq_all[t]; r++) begin
          ref_beat(t, c, r, 0, nb, d, k, l);
          total_beats += nb;
        end
      end
    end
    cycle_limit = 10 * total_beats + 200;
    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    for (int t = 0; t < NTEST; t++) begin
      @(negedge aclk);
      cur_test    = t;
      errs_before = err_cnt;
      running     = 1'b1;
      while (bursts_done < N * nreq_all[t]) begin
        @(posedge aclk);
      end
      // Quiet period catches any extra beat
      repeat (8) @(posedge aclk);
      test_bad = (err_cnt != errs_before);
      if (t == 3 && !saw_full) begin
        $display("Test %s: command FIFO never filled", test_names[t]);
        test_bad = 1'b1;
      end
      $display("Test %s: %s, %0d bursts, %0d errors", test_names[t],
               test_bad ? "FAIL" : "PASS", bursts_done, err_cnt - errs_before);
      if (test_bad) begin
        failed++;
      end
      @(negedge aclk);
      running = 1'b0;
      repeat (3) @(posedge aclk);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", NTEST, failed, err_cnt);
    if (failed == 0 && err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== design/user_wr_top.sv ====
/*
 * User write path top level
 * Arbiter, routing command queue and stream mux between the
 * user channels and the memory side
 */
`timescale 1ns/1ps
`include "wr_mux_config.svh"

module user_wr_top (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  // Channel requests
  input  logic [`WR_N_CHAN-1:0]                 req_valid,
  output logic [`WR_N_CHAN-1:0]                 req_ready,
  input  wr_mux_pkg::len_t [`WR_N_CHAN-1:0]     req_len,
  // Channel write streams
  input  logic [`WR_N_CHAN-1:0]                 s_tvalid,
  output logic [`WR_N_CHAN-1:0]                 s_tready,
  input  wr_mux_pkg::data_t [`WR_N_CHAN-1:0]    s_tdata,
  input  wr_mux_pkg::keep_t [`WR_N_CHAN-1:0]    s_tkeep,
  input  logic [`WR_N_CHAN-1:0]                 s_tlast,
  // Memory request
  output logic                                  mreq_valid,
  input  logic                                  mreq_ready,
  output wr_mux_pkg::len_t                      mreq_len,
  output wr_mux_pkg::chan_t                     mreq_chan,
  // Memory write stream
  output logic                                  m_tvalid,
  input  logic                                  m_tready,
  output wr_mux_pkg::data_t                     m_tdata,
  output wr_mux_pkg::keep_t                     m_tkeep,
  output wr_mux_pkg::chan_t                     m_tid,
  output logic                                  m_tlast
);

  import wr_mux_pkg::*;

  // Arbiter to queue
  logic  cmd_push;
  logic  cmd_full;
  chan_t push_chan;
  blen_t push_blen;

  // Queue to mux
  logic  cmd_valid;
  logic  cmd_ready;
  chan_t cmd_chan;
  blen_t cmd_blen;

  req_arbiter req_arbiter_inst (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_len    (req_len),
    .mreq_valid (mreq_valid),
    .mreq_ready (mreq_ready),
    .mreq_len   (mreq_len),
    .mreq_chan  (mreq_chan),
    .cmd_push   (cmd_push),
    .cmd_full   (cmd_full),
    .cmd_chan   (push_chan),
    .cmd_blen   (push_blen)
  );

  cmd_fifo cmd_fifo_inst (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (cmd_push),
    .push_chan (push_chan),
    .push_blen (push_blen),
    .full      (cmd_full),
    .pop_valid (cmd_valid),
    .pop_ready (cmd_ready),
    .pop_chan  (cmd_chan),
    .pop_blen  (cmd_blen)
  );

  stream_mux_wr stream_mux_wr_inst (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_chan  (cmd_chan),
    .cmd_blen  (cmd_blen),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .s_tdata   (s_tdata),
    .s_tkeep   (s_tkeep),
    .s_tlast   (s_tlast),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_tdata   (m_tdata),
    .m_tkeep   (m_tkeep),
    .m_tid     (m_tid),
    .m_tlast   (m_tlast)
  );

endmodule

// ==== wr_mux/stream_mux_wr.sv ====
/*
 * Write stream multiplexer
 * Takes routing commands and passes exactly one burst at a time
 * from the selected channel to the memory stream
 */
`timescale 1ns/1ps
`include "wr_mux_config.svh"

module stream_mux_wr (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  input  logic                                  cmd_valid,
  output logic                                  cmd_ready,
  input  wr_mux_pkg::chan_t                     cmd_chan,
  input  wr_mux_pkg::blen_t                     cmd_blen,
  input  logic [`WR_N_CHAN-1:0]                 s_tvalid,
  output logic [`WR_N_CHAN-1:0]                 s_tready,
  input  wr_mux_pkg::data_t [`WR_N_CHAN-1:0]    s_tdata,
  input  wr_mux_pkg::keep_t [`WR_N_CHAN-1:0]    s_tkeep,
  input  logic [`WR_N_CHAN-1:0]                 s_tlast,
  output logic                                  m_tvalid,
  input  logic                                  m_tready,
  output wr_mux_pkg::data_t                     m_tdata,
  output wr_mux_pkg::keep_t                     m_tkeep,
  output wr_mux_pkg::chan_t                     m_tid,
  output logic                                  m_tlast
);

  import wr_mux_pkg::*;

  // FSM and burst registers
  mux_state_t state;
  mux_state_t state_nxt;
  chan_t      sel_chan;
  blen_t      beat_cnt;

  logic beat_xfer;
  logic tr_done;
  logic cmd_take;

  // -------------------------------------------------------------------------
  // Datapath
  // -------------------------------------------------------------------------
  always_comb begin
    // Ready only to the channel owning the burst
    for (int i = 0; i < `WR_N_CHAN; i++) begin
      s_tready[i] = (state == ST_MUX) && (sel_chan == chan_t'(i)) && m_tready;
    end

    if (state == ST_MUX) begin
      m_tvalid = s_tvalid[sel_chan];
      m_tdata  = s_tdata[sel_chan];
      m_tkeep  = s_tkeep[sel_chan];
      m_tlast  = s_tlast[sel_chan];
      m_tid    = sel_chan;
    end else begin
      // Quiet bus between bursts
      m_tvalid = 1'b0;
      m_tdata  = '0;
      m_tkeep  = '0;
      m_tlast  = 1'b0;
      m_tid    = '0;
    end
  end

  assign beat_xfer = m_tvalid && m_tready;

  // Final beat of the running burst
  assign tr_done   = (state == ST_MUX) && (beat_cnt == '0) && beat_xfer;

  // Next command taken when idle or on the closing beat
  assign cmd_ready = (state == ST_IDLE) || tr_done;
  assign cmd_take  = cmd_valid && cmd_ready;

  // -------------------------------------------------------------------------
  // FSM
  // -------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (cmd_valid) begin
          state_nxt = ST_MUX;
        end
      end
      ST_MUX: begin
        // Back to back if a command waits
        if (tr_done && !cmd_valid) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= ST_IDLE;
      sel_chan <= '0;
      beat_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (cmd_take) begin
        sel_chan <= cmd_chan;
        beat_cnt <= cmd_blen;
      end else if ((state == ST_MUX) && beat_xfer) begin
        // Stalled beats leave the count frozen
        beat_cnt <= beat_cnt - 1'b1;
      end
    end
  end

endmodule

// ==== design/cmd_fifo.sv ====
/*
 * Routing command queue
 * Register-array FIFO between the arbiter and the stream mux,
 * lets several bursts wait while one is streaming
 */
`timescale 1ns/1ps
`include "wr_mux_config.svh"

module cmd_fifo (
  input  logic              aclk,
  input  logic              aresetn,
  input  logic              push,
  input  wr_mux_pkg::chan_t push_chan,
  input  wr_mux_pkg::blen_t push_blen,
  output logic              full,
  output logic              pop_valid,
  input  logic              pop_ready,
  output wr_mux_pkg::chan_t pop_chan,
  output wr_mux_pkg::blen_t pop_blen
);

  import wr_mux_pkg::*;

  localparam int PTR_BITS = (`WR_FIFO_DEPTH > 1) ? $clog2(`WR_FIFO_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(`WR_FIFO_DEPTH + 1);

  // Storage, no reset on payload
  chan_t mem_chan [`WR_FIFO_DEPTH];
  blen_t mem_blen [`WR_FIFO_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  logic wr_en;
  logic rd_en;

  assign full      = (count == CNT_BITS'(`WR_FIFO_DEPTH));
  assign pop_valid = (count != '0);
  assign wr_en     = push && !full;
  assign rd_en     = pop_valid && pop_ready;

  // Head entry straight from the array
  assign pop_chan = mem_chan[rd_ptr];
  assign pop_blen = mem_blen[rd_ptr];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem_chan[wr_ptr] <= push_chan;
      mem_blen[wr_ptr] <= push_blen;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(`WR_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(`WR_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== design/req_arbiter.sv ====
/*
 * Write request arbiter
 * Round-robin grant over the user channels, one request per handshake.
 * A grant forwards the request to memory and queues a routing command.
 */
`timescale 1ns/1ps
`include "wr_mux_config.svh"

module req_arbiter (
  input  logic                                    aclk,
  input  logic                                    aresetn,
  input  logic [`WR_N_CHAN-1:0]                   req_valid,
  output logic [`WR_N_CHAN-1:0]                   req_ready,
  input  wr_mux_pkg::len_t [`WR_N_CHAN-1:0]       req_len,
  output logic                                    mreq_valid,
  input  logic                                    mreq_ready,
  output wr_mux_pkg::len_t                        mreq_len,
  output wr_mux_pkg::chan_t                       mreq_chan,
  output logic                                    cmd_push,
  input  logic                                    cmd_full,
  output wr_mux_pkg::chan_t                       cmd_chan,
  output wr_mux_pkg::blen_t                       cmd_blen
);

  import wr_mux_pkg::*;

  // Round-robin pointer, next channel in line
  chan_t rr_ptr;

  // Search result from the pointer onward
  chan_t sel_chan;
  logic  sel_found;

  // Selection frozen while memory side stalls
  logic  locked;
  chan_t locked_chan;

  chan_t pick_chan;
  logic  pick_valid;
  logic  grant;
  len_t  len_m1;

  // -------------------------------------------------------------------------
  // Channel search
  // -------------------------------------------------------------------------
  always_comb begin
    int unsigned idx;
    sel_found = 1'b0;
    sel_chan  = rr_ptr;
    for (int k = 0; k < `WR_N_CHAN; k++) begin
      // Wrap around the channel count
      idx = (int'(rr_ptr) + k) % `WR_N_CHAN;
      if (!sel_found && req_valid[idx]) begin
        sel_found = 1'b1;
        sel_chan  = chan_t'(idx);
      end
    end
  end

  // Offered request stays put until memory takes it
  assign pick_valid = locked ? 1'b1 : sel_found;
  assign pick_chan  = locked ? locked_chan : sel_chan;

  // -------------------------------------------------------------------------
  // Handshakes
  // -------------------------------------------------------------------------
  // No offer while the command queue has no room
  assign mreq_valid = pick_valid && !cmd_full;
  assign grant      = mreq_valid && mreq_ready;

  assign mreq_chan  = pick_chan;
  assign mreq_len   = req_len[pick_chan];

  always_comb begin
    for (int i = 0; i < `WR_N_CHAN; i++) begin
      req_ready[i] = grant && (pick_chan == chan_t'(i));
    end
  end

  // Routing command pushed in the same cycle as the grant
  assign cmd_push = grant;
  assign cmd_chan = pick_chan;

  // Beats minus one = (len - 1) / bytes per beat; zero length is one beat
  assign len_m1   = mreq_len - 1'b1;
  assign cmd_blen = (mreq_len == '0) ? '0 : len_m1[`WR_LEN_BITS-1:BEAT_LOG_BITS];

  // -------------------------------------------------------------------------
  // Pointer and lock
  // -------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
      locked <= 1'b0;
    end else begin
      if (grant) begin
        // Step past the granted channel
        rr_ptr <= (pick_chan == chan_t'(`WR_N_CHAN - 1)) ? '0 : pick_chan + 1'b1;
        locked <= 1'b0;
      end else if (mreq_valid) begin
        locked <= 1'b1;
      end
    end
  end

  // Capture the offered channel while not yet locked
  always_ff @(posedge aclk) begin
    if (!locked) begin
      locked_chan <= sel_chan;
    end
  end

endmodule

// ==== common/wr_mux_pkg.sv ====
/*
 * Write path types
 * Widths of data, byte enables, lengths, beat counts and channel numbers,
 * plus the mux state encoding
 */
`include "wr_mux_config.svh"

package wr_mux_pkg;

  // Derived widths
  localparam int BEAT_LOG_BITS = $clog2(`WR_DATA_BITS / 8);
  localparam int BLEN_BITS = `WR_LEN_BITS - BEAT_LOG_BITS;
  // Single channel still needs one bit of tid
  localparam int CHAN_BITS = (`WR_N_CHAN > 1) ? $clog2(`WR_N_CHAN) : 1;

  // One beat and its byte enables
  typedef logic [`WR_DATA_BITS-1:0] data_t;
  typedef logic [`WR_DATA_BITS/8-1:0] keep_t;

  // Request length in bytes, beat count minus one
  typedef logic [`WR_LEN_BITS-1:0] len_t;
  typedef logic [BLEN_BITS-1:0] blen_t;

  // Channel number, doubles as tid
  typedef logic [CHAN_BITS-1:0] chan_t;

  // Mux FSM
  typedef enum logic [0:0] {
    ST_IDLE,
    ST_MUX
  } mux_state_t;

endpackage

// ==== common/wr_mux_config.svh ====
/*
 * Write path configuration
 * Channel count, stream width, length width and command queue depth
 */
`ifndef WR_MUX_CONFIG_SVH
`define WR_MUX_CONFIG_SVH

// Number of user channels
`define WR_N_CHAN 4

// Stream data width in bits
`define WR_DATA_BITS 64

// Byte length field width
`define WR_LEN_BITS 16

// Routing command queue entries
`define WR_FIFO_DEPTH 4

`endif
